// File: common/io_pkg.sv
package io_pkg;

  // bus widths
  typedef logic [15:0] word_t;    // data word on the io bus
  typedef logic [15:0] io_addr_t; // one-hot, one bit per register
  typedef logic [1:0]  slot_t;    // barrel slot number
  typedef logic [3:0]  kill_t;    // one bit per slot
  typedef logic [15:0] xt_t;      // task start address, bit 0 = run once

  localparam int num_slots = 4;

  // address bit numbers
  localparam int a_gpio       = 0;
  localparam int a_gpio_dir   = 1;
  localparam int a_spi_data   = 6;  // 8 bit start, rx word read
  localparam int a_spi_ctl    = 7;  // with bit 6: 16 bit start; alone: ready
  localparam int a_task1      = 8;
  localparam int a_task2      = 9;
  localparam int a_task3      = 10;
  localparam int a_task_fetch = 14; // rd: own token, wr: kill request
  localparam int a_mask_slot  = 15; // rd: slot id, wr: one-shot mask

  localparam word_t mask_all = 16'hffff;

  localparam int spi_half_period = 1; // clocks per sck half period

  // request from the core, one per cycle
  typedef struct packed {
    logic     rd;
    logic     wr;
    io_addr_t addr;
    word_t    wdata;
    slot_t    slot;
  } io_req_t;

  // same request one cycle later
  typedef struct packed {
    logic     rd;
    logic     wr;
    io_addr_t addr;  // zero when no strobe
    word_t    wdata;
    slot_t    slot;
  } io_stage_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_active;
  } spi_pins_t;

endpackage

// File: hdl/io_ctrl.sv
`timescale 1ns/1ps

module io_ctrl (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_req_t    io_req,
  output io_pkg::io_stage_t  stage,
  output io_pkg::word_t      slot_mask,
  input  io_pkg::word_t      gpio_rd,
  input  io_pkg::word_t      dir_rd,
  input  io_pkg::word_t      task_rd,
  input  io_pkg::word_t      spi_rd,
  output io_pkg::word_t      io_rdata
);

  import io_pkg::*;

  // one pending mask per slot
  word_t mask_q [num_slots];

  logic  access;   // staged rd or wr
  logic  mask_wr;  // staged write to the mask register
  word_t rd_or;    // unmasked read value

  // access stage
  // every access acts one cycle after the core issues it
  always_ff @(posedge clk) begin
    stage.wdata <= io_req.wdata;  // payload, no reset
    stage.slot  <= io_req.slot;
    if (!resetq) begin
      stage.rd   <= 1'b0;
      stage.wr   <= 1'b0;
      stage.addr <= '0;
    end else begin
      stage.rd <= io_req.rd;
      stage.wr <= io_req.wr;
      if (io_req.rd || io_req.wr)
        stage.addr <= io_req.addr;
      else
        stage.addr <= '0;  // idle cycle selects nothing
    end
  end

  assign access  = stage.rd || stage.wr;
  assign mask_wr = stage.wr && stage.addr[a_mask_slot];

  // mask of the slot owning the staged access
  assign slot_mask = mask_q[stage.slot];

  // slot masks
  // a mask write arms the mask for that slot's next access only,
  // any other access by the slot puts it back to all ones
  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 0; i < num_slots; i++)
        mask_q[i] <= mask_all;
    end else if (access) begin
      if (mask_wr)
        mask_q[stage.slot] <= stage.wdata;  // applies to next access
      else
        mask_q[stage.slot] <= mask_all;     // one shot, used up
    end
  end

  // read mux
  // task and spi values come back already selected by their modules
  always_comb begin
    rd_or = '0;
    if (stage.addr[a_gpio])
      rd_or = rd_or | gpio_rd;   // pin input
    if (stage.addr[a_gpio_dir])
      rd_or = rd_or | dir_rd;    // direction reg
    rd_or = rd_or | task_rd;     // tokens and fetch
    rd_or = rd_or | spi_rd;      // rx word and ready
    if (stage.addr[a_mask_slot])
      rd_or = rd_or | word_t'(stage.slot);  // slot id
  end

  // cleared mask bits read as zero
  assign io_rdata = rd_or & slot_mask;

endmodule

// File: hdl/gpio_port.sv
`timescale 1ns/1ps

module gpio_port (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_stage_t  stage,
  input  io_pkg::word_t      slot_mask,
  input  io_pkg::word_t      gpio_in,
  output io_pkg::word_t      gpio_out,
  output io_pkg::word_t      gpio_oe,
  output io_pkg::word_t      gpio_rd,
  output io_pkg::word_t      dir_rd
);

  import io_pkg::*;

  word_t out_q;  // output data
  word_t dir_q;  // 1 = output
  logic  out_we;
  logic  dir_we;

  // only the bits set in the mask take new data
  function automatic word_t merge(input word_t old_val, input word_t new_val,
                                  input word_t mask);
    merge = (old_val & ~mask) | (new_val & mask);
  endfunction

  assign out_we = stage.wr && stage.addr[a_gpio];
  assign dir_we = stage.wr && stage.addr[a_gpio_dir];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      out_q <= '0;
      dir_q <= '0;  // all pins input
    end else begin
      if (out_we)
        out_q <= merge(out_q, stage.wdata, slot_mask);
      if (dir_we)
        dir_q <= merge(dir_q, stage.wdata, slot_mask);
    end
  end

  assign gpio_out = out_q;
  assign gpio_oe  = dir_q;

  // data read returns the pins, not the output reg
  assign gpio_rd = gpio_in;
  assign dir_rd  = dir_q;

endmodule

// File: hdl/task_sched.sv
`timescale 1ns/1ps

module task_sched (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_stage_t  stage,
  output io_pkg::word_t      task_rd,
  output io_pkg::kill_t      kill_slot
);

  import io_pkg::*;

  // slot 0 has no token, it always starts from zero
  xt_t   tok_q [1:num_slots-1];
  kill_t kill_q;

  logic [num_slots-1:1] tok_sel;  // raw token register selects
  logic  fetch_rd;
  logic  kill_wr;
  xt_t   fetch_xt;   // token of the issuing slot
  word_t rd_or;

  assign tok_sel  = {stage.addr[a_task3], stage.addr[a_task2], stage.addr[a_task1]};
  assign fetch_rd = stage.rd && stage.addr[a_task_fetch];
  assign kill_wr  = stage.wr && stage.addr[a_task_fetch];

  // fetch value, run-once flag stripped so the xt stays even
  always_comb begin
    fetch_xt = '0;  // slot 0 gets zero
    for (int i = 1; i < num_slots; i++) begin
      if (stage.slot == slot_t'(i))
        fetch_xt = {tok_q[i][15:1], 1'b0};
    end
  end

  always_comb begin
    rd_or = '0;
    for (int i = 1; i < num_slots; i++) begin
      if (tok_sel[i])
        rd_or = rd_or | tok_q[i];  // raw, bit 0 included
    end
    if (stage.addr[a_task_fetch])
      rd_or = rd_or | fetch_xt;
  end

  assign task_rd = rd_or;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int i = 1; i < num_slots; i++)
        tok_q[i] <= '0;  // stops all tasks after reset
      kill_q <= '0;
    end else begin
      // kill request lasts one cycle
      kill_q <= kill_wr ? kill_t'(stage.wdata[num_slots-1:0]) : '0;
      for (int i = 1; i < num_slots; i++) begin
        if (stage.wr && tok_sel[i])
          tok_q[i] <= stage.wdata;  // any slot may set any token
        else if (fetch_rd && stage.slot == slot_t'(i) && tok_q[i][0])
          tok_q[i] <= '0;  // run once, gone after the fetch
      end
    end
  end

  assign kill_slot = kill_q;

endmodule

// File: spi/spi_master.sv
`timescale 1ns/1ps

module spi_master (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_stage_t  stage,
  output io_pkg::spi_pins_t  pins,
  input  logic               miso,
  output io_pkg::word_t      spi_rd
);

  import io_pkg::*;

  typedef enum logic {st_idle, st_run} spi_state_t;

  spi_state_t state_q;
  logic [3:0] div_q;    // half period counter
  logic [4:0] bits_q;   // bits left in the transfer
  logic       sck_q;
  word_t      tx_q;     // msb goes out first
  word_t      rx_q;

  logic start;
  logic wide;   // 16 bit transfer
  logic tick;   // end of a half period
  logic busy;

  assign busy  = (state_q == st_run);
  assign start = stage.wr && stage.addr[a_spi_data] && !busy;  // ignored while busy
  assign wide  = stage.addr[a_spi_ctl];
  assign tick  = (div_q == 4'(spi_half_period - 1));

  always_ff @(posedge clk) begin
    if (!resetq) begin
      state_q <= st_idle;
      div_q   <= '0;
      bits_q  <= '0;
      sck_q   <= 1'b0;  // mode 0, sck idles low
      tx_q    <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q <= st_run;
            div_q   <= '0;
            bits_q  <= wide ? 5'd16 : 5'd8;
            // byte is left aligned so both sizes shift from bit 15
            tx_q    <= wide ? stage.wdata : {stage.wdata[7:0], 8'h00};
          end
        end
        st_run: begin
          if (!tick) begin
            div_q <= div_q + 4'd1;
          end else begin
            div_q <= '0;
            if (!sck_q) begin
              sck_q <= 1'b1;  // rising, miso sampled below
            end else begin
              sck_q  <= 1'b0;                // falling
              tx_q   <= {tx_q[14:0], 1'b0};  // next mosi bit
              bits_q <= bits_q - 5'd1;
              if (bits_q == 5'd1)
                state_q <= st_idle;  // last bit done
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // receive shifter
  // cleared at start so a byte transfer reads back zero extended
  always_ff @(posedge clk) begin
    if (start)
      rx_q <= '0;
    else if (busy && tick && !sck_q)
      rx_q <= {rx_q[14:0], miso};  // sample on rising sck
  end

  assign pins.sck       = sck_q;
  assign pins.mosi      = tx_q[15];
  assign pins.cs_active = busy;

  assign spi_rd = (stage.addr[a_spi_data] ? rx_q : '0)
                | (stage.addr[a_spi_ctl] ? word_t'(!busy) : '0);  // ready flag

endmodule

// File: hdl/io_top.sv
`timescale 1ns/1ps

module io_top (
  input  logic               clk,
  input  logic               resetq,
  input  io_pkg::io_req_t    io_req,
  output io_pkg::word_t      io_rdata,
  input  io_pkg::word_t      gpio_in,
  output io_pkg::word_t      gpio_out,
  output io_pkg::word_t      gpio_oe,
  output io_pkg::spi_pins_t  spi,
  input  logic               miso,
  output io_pkg::kill_t      kill_slot
);

  import io_pkg::*;

  io_stage_t stage;      // registered access, to all datapath blocks
  word_t     slot_mask;  // mask of the staged slot
  word_t     gpio_rd;
  word_t     dir_rd;
  word_t     task_rd;
  word_t     spi_rd;

  io_ctrl u_ctrl (
    .clk       (clk),
    .resetq    (resetq),
    .io_req    (io_req),
    .stage     (stage),
    .slot_mask (slot_mask),
    .gpio_rd   (gpio_rd),
    .dir_rd    (dir_rd),
    .task_rd   (task_rd),
    .spi_rd    (spi_rd),
    .io_rdata  (io_rdata)
  );

  gpio_port u_gpio (
    .clk       (clk),
    .resetq    (resetq),
    .stage     (stage),
    .slot_mask (slot_mask),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .gpio_oe   (gpio_oe),
    .gpio_rd   (gpio_rd),
    .dir_rd    (dir_rd)
  );

  task_sched u_task (
    .clk       (clk),
    .resetq    (resetq),
    .stage     (stage),
    .task_rd   (task_rd),
    .kill_slot (kill_slot)
  );

  spi_master u_spi (
    .clk    (clk),
    .resetq (resetq),
    .stage  (stage),
    .pins   (spi),
    .miso   (miso),
    .spi_rd (spi_rd)
  );

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic resetq
);

  localparam int half_period  = 10;  // ns, 20 ns clock
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // low for 8 rising edges, released on a falling edge
  initial begin
    resetq = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    resetq = 1'b1;
  end

endmodule

// File: testbench/tb_io_top.sv
`timescale 1ns/1ps

module tb_io_top;

  import io_pkg::*;

  // tests run about 400 cycles, spi polling takes most of it
  localparam int cycle_limit = 3000;

  logic      clk;
  logic      resetq;
  io_req_t   io_req;
  word_t     io_rdata;
  word_t     gpio_in;
  word_t     gpio_out;
  word_t     gpio_oe;
  spi_pins_t spi;
  logic      miso;
  kill_t     kill_slot;

  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          tests  = 0;
  int unsigned seed;

  tb_clkgen u_clkgen (
    .clk    (clk),
    .resetq (resetq)
  );

  io_top i_dut (
    .clk       (clk),
    .resetq    (resetq),
    .io_req    (io_req),
    .io_rdata  (io_rdata),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .gpio_oe   (gpio_oe),
    .spi       (spi),
    .miso      (miso),
    .kill_slot (kill_slot)
  );

  // loopbacks
  assign gpio_in = gpio_out & gpio_oe;             // undriven pins read 0
  assign miso    = spi.cs_active ? spi.mosi : 1'b0;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_kill(input string what, input kill_t got, input kill_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_spi_pins(input string what, input spi_pins_t got,
                                input spi_pins_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s sck %b mosi %b cs %b, expected sck %b mosi %b cs %b",
               $time, what, got.sck, got.mosi, got.cs_active,
               exp.sck, exp.mosi, exp.cs_active);
    end
  endtask

  function automatic io_addr_t addr_bit(input int b);
    addr_bit = io_addr_t'(1) << b;  // one-hot select
  endfunction

  // accesses start and end on a falling edge
  task automatic io_write(input slot_t slot, input io_addr_t addr, input word_t data);
    io_req.rd    = 1'b0;
    io_req.wr    = 1'b1;
    io_req.addr  = addr;
    io_req.wdata = data;
    io_req.slot  = slot;
    @(posedge clk);  // staged here
    @(negedge clk);
    io_req = '0;
  endtask

  task automatic io_read(input slot_t slot, input io_addr_t addr, output word_t data);
    io_req.rd    = 1'b1;
    io_req.wr    = 1'b0;
    io_req.addr  = addr;
    io_req.wdata = '0;
    io_req.slot  = slot;
    @(posedge clk);
    @(negedge clk);
    data   = io_rdata;  // stage cycle, mid period
    io_req = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  task automatic test_gpio();
    int    e0;
    word_t dir;
    word_t data;
    word_t rd;
    e0   = errors;
    dir  = word_t'($urandom);
    data = word_t'($urandom);
    check_kill("kill_slot after reset", kill_slot, '0);
    check_spi_pins("spi pins after reset", spi, '0);
    check_word("gpio_oe after reset", gpio_oe, '0);
    check_word("gpio_out after reset", gpio_out, '0);
    io_read(2'd0, addr_bit(a_gpio_dir), rd);
    check_word("dir read after reset", rd, '0);
    io_read(2'd0, addr_bit(a_gpio), rd);
    check_word("gpio read after reset", rd, '0);
    io_write(2'd0, addr_bit(a_gpio_dir), dir);
    io_write(2'd0, addr_bit(a_gpio), data);
    idle(1);  // data write lands one edge later
    check_word("gpio_oe", gpio_oe, dir);
    check_word("gpio_out", gpio_out, data);
    io_read(2'd0, addr_bit(a_gpio_dir), rd);
    check_word("dir read", rd, dir);
    io_read(2'd0, addr_bit(a_gpio), rd);
    check_word("gpio read", rd, data & dir);  // inputs read 0
    end_test("reset and gpio", e0);
  endtask

  task automatic test_slot_mask();
    int    e0;
    word_t old_val;
    word_t new_val;
    word_t mask2;
    word_t mask1;
    word_t exp;
    word_t rd;
    e0      = errors;
    old_val = word_t'($urandom);
    new_val = word_t'($urandom);
    mask2   = word_t'($urandom);
    mask1   = word_t'($urandom);
    exp     = (old_val & ~mask2) | (new_val & mask2);
    io_write(2'd0, addr_bit(a_gpio_dir), mask_all);  // all outputs so reads see gpio_out
    io_write(2'd2, addr_bit(a_gpio), old_val);
    io_write(2'd2, addr_bit(a_mask_slot), mask2);
    io_write(2'd2, addr_bit(a_gpio), new_val);       // mask used up here
    idle(1);
    check_word("gpio_out after masked write", gpio_out, exp);
    io_read(2'd2, addr_bit(a_gpio), rd);
    check_word("slot 2 read after mask", rd, exp);
    // slot 3 must not see the slot 1 mask
    io_write(2'd1, addr_bit(a_mask_slot), mask1);
    io_read(2'd3, addr_bit(a_gpio), rd);
    check_word("slot 3 read", rd, exp);
    io_read(2'd1, addr_bit(a_gpio), rd);
    check_word("slot 1 masked read", rd, exp & mask1);
    io_read(2'd1, addr_bit(a_gpio), rd);
    check_word("slot 1 read after mask", rd, exp);
    end_test("slot mask", e0);
  endtask

  task automatic test_tokens();
    int    e0;
    word_t tok [1:3];
    word_t rd;
    e0 = errors;
    for (int i = 1; i < num_slots; i++) begin
      tok[i] = word_t'($urandom);
      io_write(2'd0, addr_bit(a_task1 + i - 1), tok[i]);
    end
    for (int i = 1; i < num_slots; i++) begin
      io_read(2'd0, addr_bit(a_task1 + i - 1), rd);
      check_word($sformatf("token %0d raw", i), rd, tok[i]);
    end
    for (int i = 1; i < num_slots; i++) begin
      io_read(slot_t'(i), addr_bit(a_task_fetch), rd);
      check_word($sformatf("slot %0d fetch", i), rd, tok[i] & 16'hfffe);  // flag stripped
    end
    io_read(2'd0, addr_bit(a_task_fetch), rd);
    check_word("slot 0 fetch", rd, '0);
    for (int s = 0; s < num_slots; s++) begin
      io_read(slot_t'(s), addr_bit(a_mask_slot), rd);
      check_word($sformatf("slot %0d id", s), rd, word_t'(s));
    end
    end_test("tokens", e0);
  endtask

  task automatic test_run_once();
    int    e0;
    word_t once;
    word_t keep;
    word_t rd;
    e0   = errors;
    once = word_t'($urandom) | 16'h0001;
    keep = word_t'($urandom) & 16'hfffe;
    io_write(2'd0, addr_bit(a_task2), once);
    io_write(2'd0, addr_bit(a_task3), keep);
    io_read(2'd2, addr_bit(a_task_fetch), rd);
    check_word("run-once fetch", rd, once & 16'hfffe);
    io_read(2'd0, addr_bit(a_task2), rd);
    check_word("run-once token after fetch", rd, '0);
    io_read(2'd2, addr_bit(a_task_fetch), rd);
    check_word("run-once second fetch", rd, '0);
    repeat (3) begin
      io_read(2'd3, addr_bit(a_task_fetch), rd);
      check_word("repeat fetch", rd, keep);
    end
    io_read(2'd0, addr_bit(a_task3), rd);
    check_word("kept token raw", rd, keep);
    end_test("run once", e0);
  endtask

  task automatic test_kill();
    int    e0;
    word_t data;
    e0 = errors;
    for (int n = 0; n < 3; n++) begin
      data = word_t'($urandom) | 16'h0001;  // at least one slot
      io_write(2'd0, addr_bit(a_task_fetch), data);
      check_kill("kill_slot in cycle n+1", kill_slot, '0);
      idle(1);
      check_kill("kill_slot in cycle n+2", kill_slot, kill_t'(data[3:0]));
      idle(1);
      check_kill("kill_slot in cycle n+3", kill_slot, '0);
    end
    end_test("kill", e0);
  endtask

  task automatic spi_transfer(input logic wide, input word_t data);
    io_addr_t  start_addr;
    word_t     exp;
    word_t     rd;
    spi_pins_t exp_pins;
    start_addr = addr_bit(a_spi_data);
    if (wide)
      start_addr = start_addr | addr_bit(a_spi_ctl);  // both bits, 16 bit
    exp = wide ? data : {8'h00, data[7:0]};
    exp_pins.sck       = 1'b0;
    exp_pins.mosi      = wide ? data[15] : data[7];  // msb out before the first edge
    exp_pins.cs_active = 1'b1;
    check_spi_pins("spi pins idle", spi, '0);
    io_write(2'd0, start_addr, data);
    io_read(2'd0, addr_bit(a_spi_ctl), rd);
    check_word("spi ready after start", rd, '0);
    check_spi_pins("spi pins after start", spi, exp_pins);
    io_write(2'd0, start_addr, ~data);  // busy, must be dropped
    exp_pins.sck = 1'b1;                // one half period in
    check_spi_pins("spi pins first sck high", spi, exp_pins);
    while (rd !== 16'h0001)             // poll the ready flag
      io_read(2'd0, addr_bit(a_spi_ctl), rd);
    io_read(2'd0, addr_bit(a_spi_data), rd);
    check_word(wide ? "spi 16 bit rx" : "spi 8 bit rx", rd, exp);
    check_spi_pins("spi pins after transfer", spi, '0);
  endtask

  task automatic test_spi();
    int e0;
    e0 = errors;
    for (int n = 0; n < 4; n++) begin
      spi_transfer(1'b0, word_t'($urandom));
      spi_transfer(1'b1, word_t'($urandom));
    end
    end_test("spi", e0);
  endtask

  initial begin
    seed = 32'h4449_01fb;
    void'($urandom(seed));
    io_req = '0;
    wait (resetq === 1'b1);
    @(negedge clk);
    test_gpio();
    test_slot_mask();
    test_tokens();
    test_run_once();
    test_kill();
    test_spi();
    idle(2);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: files.f
common/io_pkg.sv
hdl/io_ctrl.sv
hdl/gpio_port.sv
hdl/task_sched.sv
spi/spi_master.sv
hdl/io_top.sv
testbench/tb_clkgen.sv
testbench/tb_io_top.sv
